//--- design/lmem_pkg.sv
// Word, byte enable, address and tag types with the request and response structs of the scratchpad
`default_nettype none

package lmem_pkg;

    // Words addressed by addr_t across all banks
    localparam int ADDR_SPACE = 256;

    // One data word and its byte lanes
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byteen_t;

    // Word address, low bits pick the bank
    typedef logic [$clog2(ADDR_SPACE)-1:0] addr_t;

    // Requester tag, echoed back with read data
    typedef logic [7:0] tag_t;

    // One lane's request
    typedef struct packed {
        logic    rw;
        byteen_t byteen;
        addr_t   addr;
        word_t   data;
        tag_t    tag;
    } lmem_req_t;

    // Read response returned to a lane
    typedef struct packed {
        word_t data;
        tag_t  tag;
    } lmem_rsp_t;

endpackage

`default_nettype wire

//--- design/lmem_bank_arb.sv
// Round-robin arbiter granting one requesting lane per bank per cycle
`default_nettype none
`timescale 1ns/10ps

module lmem_bank_arb #(
    parameter int NUM_REQS = 4
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire [NUM_REQS-1:0]  cand,
    output logic [NUM_REQS-1:0] grant
);

    localparam int LANE_W = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;

    // Lane with the highest priority this cycle
    logic [LANE_W-1:0] ptr;
    logic [LANE_W-1:0] win;
    logic              found;

    // Scan from the pointer and wrap, first candidate wins
    always_comb begin
        automatic int idx = 0;
        grant = '0;
        win   = ptr;
        found = 1'b0;
        for (int i = 0; i < NUM_REQS; i++) begin
            idx = (int'(ptr) + i) % NUM_REQS;
            if (!found && cand[idx]) begin
                found      = 1'b1;
                win        = LANE_W'(idx);
                grant[idx] = 1'b1;
            end
        end
    end

    // Winner drops to lowest priority for the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (found) begin
            if (win == LANE_W'(NUM_REQS - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= win + 1'b1;
            end
        end
    end

    // Never more than one winner, and only from lanes that asked
    grant_legal_a : assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(grant) && ((grant & ~cand) == '0)
    );

endmodule

`default_nettype wire

//--- design/lmem_bank.sv
// Single-port scratchpad bank with byte-enabled write and registered read
`default_nettype none
`timescale 1ns/10ps

module lmem_bank import lmem_pkg::*; #(
    parameter int NUM_REQS  = 4,
    parameter int NUM_BANKS = 4,
    localparam int LANE_W   = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              en,
    input  wire lmem_req_t   req,
    input  wire [LANE_W-1:0] lane,
    output logic              rd_valid,
    output lmem_rsp_t         rd,
    output logic [LANE_W-1:0] rd_lane
);

    localparam int WORDS  = ADDR_SPACE / NUM_BANKS;
    localparam int IDX_W  = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam int BYTES  = $bits(byteen_t);

    word_t            mem [WORDS];
    logic [IDX_W-1:0] idx;
    logic             rd_en;

    // Bank select bits are stripped off, the rest index the word
    assign idx   = IDX_W'(req.addr / NUM_BANKS);
    assign rd_en = en && !req.rw;

    // Only enabled bytes change
    always_ff @(posedge clk) begin
        if (en && req.rw) begin
            for (int b = 0; b < BYTES; b++) begin
                if (req.byteen[b]) begin
                    mem[idx][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
    end

    // One-cycle valid pulse per read grant
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // Data, tag and lane ride together to the response side
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd.data <= mem[idx];
            rd.tag  <= req.tag;
            rd_lane <= lane;
        end
    end

    // A write grant leaves the read pipeline empty on the next cycle
    no_rd_after_wr_a : assert property (
        @(posedge clk) disable iff (reset)
        (en && req.rw) |=> !rd_valid
    );

endmodule

`default_nettype wire

//--- design/lmem_rsp_buf.sv
// Per-lane response FIFO with credit count of buffered and in-flight reads
`default_nettype none
`timescale 1ns/10ps

module lmem_rsp_buf import lmem_pkg::*; #(
    parameter int RSP_DEPTH = 4
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            issue,
    input  wire            push,
    input  wire lmem_rsp_t push_data,
    output logic           space,
    output logic           rsp_valid,
    output lmem_rsp_t      rsp,
    input  wire            rsp_ready
);

    localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
    localparam int CNT_W = $clog2(RSP_DEPTH + 1);

    lmem_rsp_t        fifo [RSP_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] credits;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(RSP_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign pop       = rsp_valid && rsp_ready;
    assign rsp_valid = (count != '0);
    assign rsp       = fifo[rd_ptr];

    // Reads already granted hold a slot until they leave the FIFO
    assign space = (credits != CNT_W'(RSP_DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({issue, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Credit gating upstream must keep the FIFO from overflowing
    no_push_full_a : assert property (
        @(posedge clk) disable iff (reset)
        push |-> (count != CNT_W'(RSP_DEPTH))
    );

endmodule

`default_nettype wire

//--- design/local_mem.sv
// Banked local memory core with bank decode, arbitration, banks and response routing
`default_nettype none
`timescale 1ns/10ps

module local_mem import lmem_pkg::*; #(
    parameter int NUM_REQS  = 4,
    parameter int NUM_BANKS = 4,
    parameter int RSP_DEPTH = 4,
    localparam int LANE_W   = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire [NUM_REQS-1:0]            req_valid,
    input  wire lmem_req_t [NUM_REQS-1:0] req,
    output logic [NUM_REQS-1:0]           req_ready,
    output logic [NUM_REQS-1:0]           rsp_valid,
    output lmem_rsp_t [NUM_REQS-1:0]      rsp,
    input  wire [NUM_REQS-1:0]            rsp_ready
);

    localparam int BSEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [NUM_REQS-1:0][BSEL_W-1:0]    bank_sel;
    logic [NUM_REQS-1:0]                lane_space;
    logic [NUM_BANKS-1:0][NUM_REQS-1:0] cand;
    logic [NUM_BANKS-1:0][NUM_REQS-1:0] grant;
    logic [NUM_REQS-1:0][NUM_BANKS-1:0] lane_grant;
    logic [NUM_BANKS-1:0]               bank_en;
    lmem_req_t [NUM_BANKS-1:0]          bank_req;
    logic [NUM_BANKS-1:0][LANE_W-1:0]   bank_lane;
    logic [NUM_BANKS-1:0]               rd_valid;
    lmem_rsp_t [NUM_BANKS-1:0]          rd;
    logic [NUM_BANKS-1:0][LANE_W-1:0]   rd_lane;
    logic [NUM_REQS-1:0]                issue;
    logic [NUM_REQS-1:0]                push;
    lmem_rsp_t [NUM_REQS-1:0]           push_data;

    // Low address bits pick the bank
    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            bank_sel[i] = BSEL_W'(req[i].addr % NUM_BANKS);
        end
    end

    // Lanes without response space stay out of arbitration
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int i = 0; i < NUM_REQS; i++) begin
                cand[b][i] = req_valid[i] && lane_space[i] && (bank_sel[i] == BSEL_W'(b));
            end
        end
    end

    // Winner's request and lane index go to the bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_en[b]   = |grant[b];
            bank_lane[b] = '0;
            for (int i = 0; i < NUM_REQS; i++) begin
                if (grant[b][i]) begin
                    bank_lane[b] = LANE_W'(i);
                end
            end
            bank_req[b] = req[bank_lane[b]];
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                lane_grant[i][b] = grant[b][i];
            end
            req_ready[i] = |lane_grant[i];
            issue[i]     = req_ready[i] && !req[i].rw;
        end
    end

    // At most one bank returns a read for a lane per cycle
    always_comb begin
        for (int i = 0; i < NUM_REQS; i++) begin
            push[i]      = 1'b0;
            push_data[i] = rd[0];
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (rd_valid[b] && (rd_lane[b] == LANE_W'(i))) begin
                    push[i]      = 1'b1;
                    push_data[i] = rd[b];
                end
            end
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        lmem_bank_arb #(
            .NUM_REQS (NUM_REQS)
        ) arb (
            .clk   (clk),
            .reset (reset),
            .cand  (cand[b]),
            .grant (grant[b])
        );

        lmem_bank #(
            .NUM_REQS  (NUM_REQS),
            .NUM_BANKS (NUM_BANKS)
        ) bank (
            .clk      (clk),
            .reset    (reset),
            .en       (bank_en[b]),
            .req      (bank_req[b]),
            .lane     (bank_lane[b]),
            .rd_valid (rd_valid[b]),
            .rd       (rd[b]),
            .rd_lane  (rd_lane[b])
        );
    end

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_lane
        lmem_rsp_buf #(
            .RSP_DEPTH (RSP_DEPTH)
        ) rsp_buf (
            .clk       (clk),
            .reset     (reset),
            .issue     (issue[i]),
            .push      (push[i]),
            .push_data (push_data[i]),
            .space     (lane_space[i]),
            .rsp_valid (rsp_valid[i]),
            .rsp       (rsp[i]),
            .rsp_ready (rsp_ready[i])
        );

        // A lane's request may be taken by one bank only
        single_bank_grant_a : assert property (
            @(posedge clk) disable iff (reset)
            $onehot0(lane_grant[i])
        );
    end

endmodule

`default_nettype wire

//--- design/local_mem_top.sv
// Flat-port top level packing lane signals into structs around the local memory core
`default_nettype none
`timescale 1ns/10ps

module local_mem_top import lmem_pkg::*; #(
    parameter int NUM_REQS  = 4,
    parameter int NUM_BANKS = 4,
    parameter int RSP_DEPTH = 4
) (
    input  wire                         clk,
    input  wire                         reset,

    // Lane requests
    input  wire [NUM_REQS-1:0]          mem_req_valid,
    input  wire [NUM_REQS-1:0]          mem_req_rw,
    input  wire byteen_t [NUM_REQS-1:0] mem_req_byteen,
    input  wire addr_t [NUM_REQS-1:0]   mem_req_addr,
    input  wire word_t [NUM_REQS-1:0]   mem_req_data,
    input  wire tag_t [NUM_REQS-1:0]    mem_req_tag,
    output wire [NUM_REQS-1:0]          mem_req_ready,

    // Lane responses
    output wire [NUM_REQS-1:0]          mem_rsp_valid,
    output wire word_t [NUM_REQS-1:0]   mem_rsp_data,
    output wire tag_t [NUM_REQS-1:0]    mem_rsp_tag,
    input  wire [NUM_REQS-1:0]          mem_rsp_ready
);

    wire lmem_req_t [NUM_REQS-1:0] req;
    wire lmem_rsp_t [NUM_REQS-1:0] rsp;

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_pack
        assign req[i] = '{
            rw:     mem_req_rw[i],
            byteen: mem_req_byteen[i],
            addr:   mem_req_addr[i],
            data:   mem_req_data[i],
            tag:    mem_req_tag[i]
        };
        assign mem_rsp_data[i] = rsp[i].data;
        assign mem_rsp_tag[i]  = rsp[i].tag;
    end

    local_mem #(
        .NUM_REQS  (NUM_REQS),
        .NUM_BANKS (NUM_BANKS),
        .RSP_DEPTH (RSP_DEPTH)
    ) core (
        .clk       (clk),
        .reset     (reset),
        .req_valid (mem_req_valid),
        .req       (req),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp       (rsp),
        .rsp_ready (mem_rsp_ready)
    );

endmodule

`default_nettype wire

//--- sim/local_mem_tb.sv
// Table-driven testbench for the banked local memory with shadow memory and random back-pressure
`default_nettype none
`timescale 1ns/10ps

module local_mem_tb import lmem_pkg::*; ();

    localparam int NUM_REQS    = 4;
    localparam int NUM_BANKS   = 4;
    localparam int NUM_ROWS    = 12;
    localparam int MAX_CYCLES  = 40 * NUM_ROWS;
    localparam int IDLE_CYCLES = 4;

    // One lane's entry in a stimulus row
    typedef struct packed {
        logic    valid;
        logic    rw;
        byteen_t byteen;
        addr_t   addr;
        word_t   data;
        tag_t    tag;
    } entry_t;

    logic                   clk;
    logic                   reset;
    logic [NUM_REQS-1:0]    req_valid;
    logic [NUM_REQS-1:0]    req_rw;
    byteen_t [NUM_REQS-1:0] req_byteen;
    addr_t [NUM_REQS-1:0]   req_addr;
    word_t [NUM_REQS-1:0]   req_data;
    tag_t [NUM_REQS-1:0]    req_tag;
    wire [NUM_REQS-1:0]     req_ready;
    wire [NUM_REQS-1:0]     rsp_valid;
    wire word_t [NUM_REQS-1:0] rsp_data;
    wire tag_t [NUM_REQS-1:0]  rsp_tag;
    logic [NUM_REQS-1:0]    rsp_ready;

    entry_t              stim [NUM_ROWS][NUM_REQS];
    word_t               shadow [ADDR_SPACE];
    lmem_rsp_t           exp_q [NUM_REQS][$];
    logic [NUM_REQS-1:0] pending;
    logic [15:0]         lfsr;
    int                  cycles = 0;
    int                  errors = 0;
    int                  checks = 0;

    local_mem_top dut (
        .clk            (clk),
        .reset          (reset),
        .mem_req_valid  (req_valid),
        .mem_req_rw     (req_rw),
        .mem_req_byteen (req_byteen),
        .mem_req_addr   (req_addr),
        .mem_req_data   (req_data),
        .mem_req_tag    (req_tag),
        .mem_req_ready  (req_ready),
        .mem_rsp_valid  (rsp_valid),
        .mem_rsp_data   (rsp_data),
        .mem_rsp_tag    (rsp_tag),
        .mem_rsp_ready  (rsp_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Run limit scaled to the number of stimulus rows
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run passed %0d cycles with work still outstanding", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata, input byteen_t be);
        word_t res;
        res = old;
        for (int b = 0; b < $bits(byteen_t); b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Fewest cycles a row can take, one grant per bank per cycle
    function automatic int min_row_cycles(input int row);
        int load [NUM_BANKS];
        int most;
        most = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            load[b] = 0;
        end
        for (int l = 0; l < NUM_REQS; l++) begin
            if (stim[row][l].valid) begin
                load[stim[row][l].addr % NUM_BANKS]++;
            end
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (load[b] > most) begin
                most = load[b];
            end
        end
        return most;
    endfunction

    function automatic logic queues_busy();
        for (int l = 0; l < NUM_REQS; l++) begin
            if (exp_q[l].size() != 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic set_entry(input int row, input int lane, input logic rw, input byteen_t be,
                             input addr_t addr, input word_t data, input tag_t tag);
        stim[row][lane] = '{valid: 1'b1, rw: rw, byteen: be, addr: addr, data: data, tag: tag};
    endtask

    task automatic load_stim();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int l = 0; l < NUM_REQS; l++) begin
                stim[r][l] = '0;
            end
        end
        // Full writes, one per bank, then four into bank 0
        set_entry(0, 0, 1'b1, 4'hf, 8'h00, 32'ha0a0_0000, 8'h01);
        set_entry(0, 1, 1'b1, 4'hf, 8'h01, 32'ha1a1_1111, 8'h02);
        set_entry(0, 2, 1'b1, 4'hf, 8'h02, 32'ha2a2_2222, 8'h03);
        set_entry(0, 3, 1'b1, 4'hf, 8'h03, 32'ha3a3_3333, 8'h04);
        set_entry(1, 0, 1'b1, 4'hf, 8'h04, 32'hb0b0_0404, 8'h05);
        set_entry(1, 1, 1'b1, 4'hf, 8'h08, 32'hb1b1_0808, 8'h06);
        set_entry(1, 2, 1'b1, 4'hf, 8'h0c, 32'hb2b2_0c0c, 8'h07);
        set_entry(1, 3, 1'b1, 4'hf, 8'h10, 32'hb3b3_1010, 8'h08);
        set_entry(2, 0, 1'b0, 4'h0, 8'h00, 32'h0, 8'h10);
        set_entry(2, 1, 1'b0, 4'h0, 8'h01, 32'h0, 8'h11);
        set_entry(2, 2, 1'b0, 4'h0, 8'h02, 32'h0, 8'h12);
        set_entry(2, 3, 1'b0, 4'h0, 8'h03, 32'h0, 8'h13);
        set_entry(3, 0, 1'b0, 4'h0, 8'h04, 32'h0, 8'h14);
        set_entry(3, 1, 1'b0, 4'h0, 8'h08, 32'h0, 8'h15);
        set_entry(3, 2, 1'b0, 4'h0, 8'h0c, 32'h0, 8'h16);
        set_entry(3, 3, 1'b0, 4'h0, 8'h10, 32'h0, 8'h17);
        // Partial writes merge into earlier words
        set_entry(4, 0, 1'b1, 4'h3, 8'h00, 32'h1234_5678, 8'h18);
        set_entry(4, 1, 1'b1, 4'hc, 8'h01, 32'hdead_beef, 8'h19);
        set_entry(4, 2, 1'b1, 4'h5, 8'h08, 32'hcafe_f00d, 8'h1a);
        set_entry(4, 3, 1'b1, 4'h8, 8'h10, 32'h7700_0000, 8'h1b);
        set_entry(5, 0, 1'b0, 4'h0, 8'h00, 32'h0, 8'h20);
        set_entry(5, 1, 1'b0, 4'h0, 8'h01, 32'h0, 8'h21);
        set_entry(5, 2, 1'b0, 4'h0, 8'h08, 32'h0, 8'h22);
        set_entry(5, 3, 1'b0, 4'h0, 8'h10, 32'h0, 8'h23);
        // Mixed row with an idle lane
        set_entry(6, 0, 1'b1, 4'hf, 8'h20, 32'h5555_aaaa, 8'h24);
        set_entry(6, 1, 1'b0, 4'h0, 8'h04, 32'h0, 8'h25);
        set_entry(6, 3, 1'b0, 4'h0, 8'h03, 32'h0, 8'h26);
        set_entry(7, 0, 1'b0, 4'h0, 8'h20, 32'h0, 8'h27);
        set_entry(7, 1, 1'b0, 4'h0, 8'h0c, 32'h0, 8'h28);
        set_entry(7, 2, 1'b0, 4'h0, 8'h04, 32'h0, 8'h29);
        set_entry(7, 3, 1'b0, 4'h0, 8'h20, 32'h0, 8'h2a);
        // Write-only row, nothing should come back
        set_entry(8, 0, 1'b1, 4'hf, 8'h41, 32'hc1c1_4141, 8'h2b);
        set_entry(8, 1, 1'b1, 4'hf, 8'h42, 32'hc2c2_4242, 8'h2c);
        set_entry(8, 2, 1'b1, 4'hf, 8'h43, 32'hc3c3_4343, 8'h2d);
        set_entry(8, 3, 1'b1, 4'hf, 8'h44, 32'hc4c4_4444, 8'h2e);
        set_entry(9, 0, 1'b0, 4'h0, 8'h44, 32'h0, 8'h30);
        set_entry(9, 1, 1'b0, 4'h0, 8'h43, 32'h0, 8'h31);
        set_entry(9, 2, 1'b0, 4'h0, 8'h42, 32'h0, 8'h32);
        set_entry(9, 3, 1'b0, 4'h0, 8'h41, 32'h0, 8'h33);
        set_entry(10, 0, 1'b0, 4'h0, 8'h01, 32'h0, 8'h34);
        set_entry(10, 1, 1'b0, 4'h0, 8'h41, 32'h0, 8'h35);
        set_entry(10, 2, 1'b0, 4'h0, 8'h01, 32'h0, 8'h36);
        set_entry(10, 3, 1'b0, 4'h0, 8'h41, 32'h0, 8'h37);
        set_entry(11, 0, 1'b0, 4'h0, 8'h20, 32'h0, 8'h38);
        set_entry(11, 1, 1'b0, 4'h0, 8'h00, 32'h0, 8'h39);
        set_entry(11, 2, 1'b0, 4'h0, 8'h10, 32'h0, 8'h3a);
        set_entry(11, 3, 1'b0, 4'h0, 8'h08, 32'h0, 8'h3b);
    endtask

    // Lanes still waiting keep their entry on the bus
    task automatic drive_lanes(input int row);
        for (int l = 0; l < NUM_REQS; l++) begin
            req_valid[l]  = pending[l];
            req_rw[l]     = stim[row][l].rw;
            req_byteen[l] = stim[row][l].byteen;
            req_addr[l]   = stim[row][l].addr;
            req_data[l]   = stim[row][l].data;
            req_tag[l]    = stim[row][l].tag;
        end
    endtask

    task automatic pick_rsp_ready();
        for (int l = 0; l < NUM_REQS; l++) begin
            lfsr         = lfsr_step(lfsr);
            rsp_ready[l] = lfsr[0];
        end
    endtask

    task automatic check_responses();
        lmem_rsp_t want;
        for (int l = 0; l < NUM_REQS; l++) begin
            if (rsp_valid[l] && rsp_ready[l]) begin
                checks++;
                if (exp_q[l].size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: lane %0d returned tag %h with no read outstanding",
                             $time, l, rsp_tag[l]);
                end else begin
                    want = exp_q[l].pop_front();
                    if (rsp_data[l] !== want.data || rsp_tag[l] !== want.tag) begin
                        errors++;
                        $display("ERROR at %0t: lane %0d got data %h tag %h, expected %h tag %h",
                                 $time, l, rsp_data[l], rsp_tag[l], want.data, want.tag);
                    end
                end
            end
        end
    endtask

    // Transfers seen before the edge, shadow follows table order
    task automatic accept_requests(input int row);
        entry_t    e;
        lmem_rsp_t want;
        for (int l = 0; l < NUM_REQS; l++) begin
            e = stim[row][l];
            if (req_ready[l] && !req_valid[l]) begin
                errors++;
                $display("ERROR at %0t: lane %0d ready without a valid request", $time, l);
            end
            if (req_valid[l] && req_ready[l]) begin
                pending[l] = 1'b0;
                if (e.rw) begin
                    shadow[e.addr] = merge_bytes(shadow[e.addr], e.data, e.byteen);
                end else begin
                    want.data = shadow[e.addr];
                    want.tag  = e.tag;
                    exp_q[l].push_back(want);
                end
            end
        end
    endtask

    task automatic run_cycle(input int row);
        @(posedge clk);
        #1;
        drive_lanes(row);
        pick_rsp_ready();
        @(negedge clk);
        check_responses();
        accept_requests(row);
    endtask

    initial begin
        int row_cycles;
        reset      = 1'b1;
        req_valid  = '0;
        req_rw     = '0;
        req_byteen = '0;
        req_addr   = '0;
        req_data   = '0;
        req_tag    = '0;
        rsp_ready  = '0;
        pending    = '0;
        lfsr       = 16'd8;
        load_stim();
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // Quiet outputs while no lane asks
        repeat (IDLE_CYCLES) begin
            run_cycle(0);
            if (rsp_valid !== '0 || req_ready !== '0) begin
                errors++;
                $display("ERROR at %0t: outputs active before any request, rsp_valid %b ready %b",
                         $time, rsp_valid, req_ready);
            end
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_cycles = 0;
            for (int l = 0; l < NUM_REQS; l++) begin
                pending[l] = stim[r][l].valid;
            end
            while (pending != '0) begin
                run_cycle(r);
                row_cycles++;
            end
            if (row_cycles < min_row_cycles(r)) begin
                errors++;
                $display("ERROR at %0t: row %0d took %0d cycles, bank conflicts need %0d",
                         $time, r, row_cycles, min_row_cycles(r));
            end
        end

        // Drain the outstanding reads, then look for stray responses
        while (queues_busy()) begin
            run_cycle(0);
        end
        repeat (IDLE_CYCLES) begin
            run_cycle(0);
        end
        if (rsp_valid !== '0) begin
            errors++;
            $display("ERROR at %0t: responses %b left over after all reads returned",
                     $time, rsp_valid);
        end

        $display("Response checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
design/lmem_pkg.sv
design/lmem_bank_arb.sv
design/lmem_bank.sv
design/lmem_rsp_buf.sv
design/local_mem.sv
design/local_mem_top.sv
sim/local_mem_tb.sv

//--- Makefile
# Verilator flow for the local memory testbench

VERILATOR ?= verilator
TOP       ?= local_mem_tb
RTL_TOP   ?= local_mem_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

FAIL_MSG  := Testbench failed
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard design/*.sv sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only --assert $(VFLAGS) $(filter design/%,$(shell cat $(FILELIST))) \
		--top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides the result, a crash counts as failure too
sim: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
